// ==== src/axi_slv_pkg.sv ====
package axi_slv_pkg;

    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 64;
    localparam int DATA_BYTES = DATA_BITS / 8;
    localparam int ID_BITS    = 4;

    localparam int BANK_WORDS     = 256;
    localparam int BANK_ADDR_BITS = $clog2(BANK_WORDS);  // word index from addr[10:3]

    // wrap bursts stay inside an aligned 32-byte block
    localparam int WRAP_BOUNDARY_BITS = 5;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        rd_wait,
        rd_hold,   // AR taken, waiting for the write side
        rd_trans
    } rd_state_e;

    typedef enum logic {
        wr_wait,
        wr_trans
    } wr_state_e;

    // bytes per beat
    function automatic logic [7:0] size_to_bytes(input logic [2:0] size);
        return 8'd1 << size;
    endfunction

endpackage

// ==== src/axi_slv.sv ====
module axi_slv (
    input  logic                                     i_clk,
    input  logic                                     i_nrst,
    input  logic                                     i_aw_valid,
    output logic                                     o_aw_ready,
    input  logic [axi_slv_pkg::ADDR_BITS-1:0]        i_aw_addr,
    input  logic [axi_slv_pkg::ID_BITS-1:0]          i_aw_id,
    input  logic [7:0]                               i_aw_len,
    input  logic [2:0]                               i_aw_size,
    input  logic [1:0]                               i_aw_burst,
    input  logic                                     i_w_valid,
    output logic                                     o_w_ready,
    input  logic [axi_slv_pkg::DATA_BITS-1:0]        i_w_data,
    input  logic [axi_slv_pkg::DATA_BYTES-1:0]       i_w_strb,
    output logic                                     o_b_valid,
    input  logic                                     i_b_ready,
    output logic [axi_slv_pkg::ID_BITS-1:0]          o_b_id,
    output logic [1:0]                               o_b_resp,
    input  logic                                     i_ar_valid,
    output logic                                     o_ar_ready,
    input  logic [axi_slv_pkg::ADDR_BITS-1:0]        i_ar_addr,
    input  logic [axi_slv_pkg::ID_BITS-1:0]          i_ar_id,
    input  logic [7:0]                               i_ar_len,
    input  logic [2:0]                               i_ar_size,
    input  logic [1:0]                               i_ar_burst,
    output logic                                     o_r_valid,
    input  logic                                     i_r_ready,
    output logic [axi_slv_pkg::DATA_BITS-1:0]        o_r_data,
    output logic [axi_slv_pkg::ID_BITS-1:0]          o_r_id,
    output logic [1:0]                               o_r_resp,
    output logic                                     o_r_last,
    input  logic                                     i_ready,
    input  logic [axi_slv_pkg::DATA_BITS-1:0]        i_rdata,
    output logic                                     o_re,
    output logic                                     o_r32,
    output logic [axi_slv_pkg::BANK_ADDR_BITS-1:0]   o_radr,
    output logic                                     o_we,
    output logic [axi_slv_pkg::BANK_ADDR_BITS-1:0]   o_wadr,
    output logic [axi_slv_pkg::DATA_BYTES-1:0]       o_wstrb,
    output logic [axi_slv_pkg::DATA_BITS-1:0]        o_wdata
);

    function automatic logic [axi_slv_pkg::ADDR_BITS-1:0] next_addr(
        input logic [axi_slv_pkg::ADDR_BITS-1:0] addr,
        input logic [7:0]                        incr,
        input axi_slv_pkg::axi_burst_e           burst
    );
        logic [axi_slv_pkg::ADDR_BITS-1:0] nxt;
        nxt = addr;  // fixed burst repeats
        case (burst)
            axi_slv_pkg::BURST_INCR: begin
                nxt[11:0] = addr[11:0] + {4'd0, incr};  // no 4 KiB page crossing
            end
            axi_slv_pkg::BURST_WRAP: begin
                nxt[axi_slv_pkg::WRAP_BOUNDARY_BITS-1:0] =
                    addr[axi_slv_pkg::WRAP_BOUNDARY_BITS-1:0]
                    + incr[axi_slv_pkg::WRAP_BOUNDARY_BITS-1:0];
            end
            default: ;
        endcase
        return nxt;
    endfunction

    axi_slv_pkg::rd_state_e rd_state;
    axi_slv_pkg::wr_state_e wr_state;

    logic [axi_slv_pkg::ADDR_BITS-1:0] raddr;  // next address to request from the bank
    logic [7:0]                        rsize;
    axi_slv_pkg::axi_burst_e           rburst;
    logic [7:0]                        rlen;
    logic [axi_slv_pkg::ID_BITS-1:0]   rid;
    logic                              rskip;
    logic [axi_slv_pkg::DATA_BITS-1:0] skip_rdata;
    logic                              rd_swap;  // bank output holds an upper word

    logic [axi_slv_pkg::ADDR_BITS-1:0] rd_addr;
    logic                              rd_is32;
    logic                              rd_free;
    logic                              rd_last;
    logic                              rd_adv;
    logic                              ar_hs;
    logic                              r_hs;
    logic [axi_slv_pkg::DATA_BITS-1:0] rd_data;

    logic [axi_slv_pkg::ADDR_BITS-1:0] waddr;
    logic [7:0]                        wsize;
    axi_slv_pkg::axi_burst_e           wburst;
    logic [7:0]                        wlen;
    logic [axi_slv_pkg::ID_BITS-1:0]   wid;
    logic                              b_valid;
    logic                              aw_hs;
    logic                              w_hs;

    // writes win and nothing starts before the bank sweep is over
    assign rd_free = !i_aw_valid && (wr_state == axi_slv_pkg::wr_wait) && i_ready;
    assign rd_last = (rlen == 8'd0);
    assign r_hs    = o_r_valid && i_r_ready;
    assign ar_hs   = i_ar_valid && o_ar_ready;
    assign rd_adv  = ((rd_state == axi_slv_pkg::rd_hold) && o_re) || (r_hs && !rd_last);

    always_comb begin
        o_ar_ready = 1'b0;
        o_re       = 1'b0;
        rd_addr    = raddr;
        rd_is32    = (rsize == 8'd4);
        case (rd_state)
            axi_slv_pkg::rd_wait: o_ar_ready = 1'b1;
            axi_slv_pkg::rd_hold: o_re = rd_free;
            axi_slv_pkg::rd_trans: begin
                o_re       = |rlen;  // prefetch the next beat
                o_ar_ready = r_hs && rd_last;
            end
            default: ;
        endcase
        if (o_ar_ready) begin
            rd_addr = i_ar_addr;
            rd_is32 = (i_ar_size == 3'd2);
            o_re    = i_ar_valid && rd_free;
        end
    end

    assign o_radr = rd_addr[axi_slv_pkg::BANK_ADDR_BITS+2:3];
    assign o_r32  = rd_is32 && rd_addr[2];

    // upper word mirrored into both halves
    assign rd_data   = rd_swap ? {2{i_rdata[63:32]}} : i_rdata;
    assign o_r_valid = (rd_state == axi_slv_pkg::rd_trans) && i_ready;
    assign o_r_data  = rskip ? skip_rdata : rd_data;
    assign o_r_last  = (rd_state == axi_slv_pkg::rd_trans) && rd_last;
    assign o_r_id    = rid;
    assign o_r_resp  = axi_slv_pkg::RESP_OKAY;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_state <= axi_slv_pkg::rd_wait;
            rlen     <= 8'd0;
            rskip    <= 1'b0;
            rd_swap  <= 1'b0;
        end else begin
            if (o_re) begin
                rd_swap <= o_r32;
            end
            if (ar_hs) begin
                rlen     <= i_ar_len;
                rd_state <= o_re ? axi_slv_pkg::rd_trans : axi_slv_pkg::rd_hold;
            end else if (rd_state == axi_slv_pkg::rd_hold && o_re) begin
                rd_state <= axi_slv_pkg::rd_trans;
            end else if (r_hs) begin
                if (rd_last) begin
                    rd_state <= axi_slv_pkg::rd_wait;
                end else begin
                    rlen <= rlen - 8'd1;
                end
            end
            if (r_hs) begin
                rskip <= 1'b0;
            end else if (o_r_valid) begin
                rskip <= 1'b1;  // beat stalled by the master
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (ar_hs) begin
            rid    <= i_ar_id;
            rsize  <= axi_slv_pkg::size_to_bytes(i_ar_size);
            rburst <= axi_slv_pkg::axi_burst_e'(i_ar_burst);
            raddr  <= o_re ? next_addr(i_ar_addr, axi_slv_pkg::size_to_bytes(i_ar_size),
                                       axi_slv_pkg::axi_burst_e'(i_ar_burst))
                           : i_ar_addr;
        end else if (rd_adv) begin
            raddr <= next_addr(raddr, rsize, rburst);
        end
        if (o_r_valid && !i_r_ready && !rskip) begin
            skip_rdata <= rd_data;
        end
    end

    // no new AW while a read burst is streaming or a B is pending
    assign o_aw_ready = (wr_state == axi_slv_pkg::wr_wait) && !b_valid
                        && ((rd_state != axi_slv_pkg::rd_trans) || rd_last);
    assign aw_hs      = i_aw_valid && o_aw_ready;
    assign o_w_ready  = (wr_state == axi_slv_pkg::wr_trans) && i_ready;
    assign w_hs       = i_w_valid && o_w_ready;

    assign o_we    = (wr_state == axi_slv_pkg::wr_trans) && i_w_valid;
    assign o_wadr  = waddr[axi_slv_pkg::BANK_ADDR_BITS+2:3];
    assign o_wstrb = i_w_strb;
    assign o_wdata = i_w_data;

    assign o_b_valid = b_valid;
    assign o_b_id    = wid;
    assign o_b_resp  = axi_slv_pkg::RESP_OKAY;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_state <= axi_slv_pkg::wr_wait;
            wlen     <= 8'd0;
            b_valid  <= 1'b0;
        end else begin
            if (aw_hs) begin
                wr_state <= axi_slv_pkg::wr_trans;
                wlen     <= i_aw_len;
            end else if (w_hs) begin
                if (wlen == 8'd0) begin
                    wr_state <= axi_slv_pkg::wr_wait;
                    b_valid  <= 1'b1;
                end else begin
                    wlen <= wlen - 8'd1;
                end
            end
            if (b_valid && i_b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (aw_hs) begin
            waddr  <= i_aw_addr;
            wid    <= i_aw_id;
            wsize  <= axi_slv_pkg::size_to_bytes(i_aw_size);
            wburst <= axi_slv_pkg::axi_burst_e'(i_aw_burst);
        end else if (w_hs) begin
            waddr <= next_addr(waddr, wsize, wburst);
        end
    end

endmodule

// ==== src/sram_bank.sv ====
module sram_bank (
    input  logic                                     i_clk,
    input  logic                                     i_nrst,
    input  logic                                     i_re,
    input  logic                                     i_r32,
    input  logic [axi_slv_pkg::BANK_ADDR_BITS-1:0]   i_radr,
    input  logic                                     i_we,
    input  logic [axi_slv_pkg::BANK_ADDR_BITS-1:0]   i_wadr,
    input  logic [axi_slv_pkg::DATA_BYTES-1:0]       i_wstrb,
    input  logic [axi_slv_pkg::DATA_BITS-1:0]        i_wdata,
    output logic                                     o_ready,
    output logic [axi_slv_pkg::DATA_BITS-1:0]        o_rdata
);

    logic [axi_slv_pkg::DATA_BITS-1:0]      mem [axi_slv_pkg::BANK_WORDS];
    logic [axi_slv_pkg::BANK_ADDR_BITS-1:0] sweep_cnt;
    logic                                   sweep_done;
    logic [axi_slv_pkg::DATA_BITS/2-1:0]    rd_lo;
    logic [axi_slv_pkg::DATA_BITS/2-1:0]    rd_hi;

    // zeroing sweep, one word per clock
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sweep_cnt  <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (int'(sweep_cnt) == axi_slv_pkg::BANK_WORDS - 1) begin
                sweep_done <= 1'b1;
            end
        end
    end

    assign o_ready = sweep_done;

    always_ff @(posedge i_clk) begin
        if (!sweep_done) begin
            mem[sweep_cnt] <= '0;
        end else if (i_we) begin
            for (int i = 0; i < axi_slv_pkg::DATA_BYTES; i++) begin
                if (i_wstrb[i]) begin
                    mem[i_wadr][8*i +: 8] <= i_wdata[8*i +: 8];
                end
            end
        end
    end

    // an upper-word read leaves the lower half idle
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            rd_hi <= mem[i_radr][axi_slv_pkg::DATA_BITS-1:axi_slv_pkg::DATA_BITS/2];
            if (!i_r32) begin
                rd_lo <= mem[i_radr][axi_slv_pkg::DATA_BITS/2-1:0];
            end
        end
    end

    assign o_rdata = {rd_hi, rd_lo};

endmodule

// ==== src/axi_sram_top.sv ====
module axi_sram_top (
    input  logic                                 i_clk,
    input  logic                                 i_nrst,
    input  logic                                 i_aw_valid,
    output logic                                 o_aw_ready,
    input  logic [axi_slv_pkg::ADDR_BITS-1:0]    i_aw_addr,
    input  logic [axi_slv_pkg::ID_BITS-1:0]      i_aw_id,
    input  logic [7:0]                           i_aw_len,
    input  logic [2:0]                           i_aw_size,
    input  logic [1:0]                           i_aw_burst,
    input  logic                                 i_w_valid,
    output logic                                 o_w_ready,
    input  logic [axi_slv_pkg::DATA_BITS-1:0]    i_w_data,
    input  logic [axi_slv_pkg::DATA_BYTES-1:0]   i_w_strb,
    output logic                                 o_b_valid,
    input  logic                                 i_b_ready,
    output logic [axi_slv_pkg::ID_BITS-1:0]      o_b_id,
    output logic [1:0]                           o_b_resp,
    input  logic                                 i_ar_valid,
    output logic                                 o_ar_ready,
    input  logic [axi_slv_pkg::ADDR_BITS-1:0]    i_ar_addr,
    input  logic [axi_slv_pkg::ID_BITS-1:0]      i_ar_id,
    input  logic [7:0]                           i_ar_len,
    input  logic [2:0]                           i_ar_size,
    input  logic [1:0]                           i_ar_burst,
    output logic                                 o_r_valid,
    input  logic                                 i_r_ready,
    output logic [axi_slv_pkg::DATA_BITS-1:0]    o_r_data,
    output logic [axi_slv_pkg::ID_BITS-1:0]      o_r_id,
    output logic [1:0]                           o_r_resp,
    output logic                                 o_r_last
);

    // bridge to bank
    logic                                   bank_re;
    logic                                   bank_r32;
    logic [axi_slv_pkg::BANK_ADDR_BITS-1:0] bank_radr;
    logic                                   bank_we;
    logic [axi_slv_pkg::BANK_ADDR_BITS-1:0] bank_wadr;
    logic [axi_slv_pkg::DATA_BYTES-1:0]     bank_wstrb;
    logic [axi_slv_pkg::DATA_BITS-1:0]      bank_wdata;
    logic                                   bank_ready;
    logic [axi_slv_pkg::DATA_BITS-1:0]      bank_rdata;

    axi_slv u_slv (
        .*,
        .i_ready (bank_ready),
        .i_rdata (bank_rdata),
        .o_re    (bank_re),
        .o_r32   (bank_r32),
        .o_radr  (bank_radr),
        .o_we    (bank_we),
        .o_wadr  (bank_wadr),
        .o_wstrb (bank_wstrb),
        .o_wdata (bank_wdata)
    );

    sram_bank u_bank (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_re    (bank_re),
        .i_r32   (bank_r32),
        .i_radr  (bank_radr),
        .i_we    (bank_we),
        .i_wadr  (bank_wadr),
        .i_wstrb (bank_wstrb),
        .i_wdata (bank_wdata),
        .o_ready (bank_ready),
        .o_rdata (bank_rdata)
    );

endmodule

// ==== verification/axi_sram_asserts.sv ====
module axi_sram_asserts (
    input logic                                 i_clk,
    input logic                                 i_nrst,
    input logic                                 i_r_valid,
    input logic                                 i_r_ready,
    input logic [axi_slv_pkg::DATA_BITS-1:0]    i_r_data,
    input logic                                 i_r_last,
    input logic                                 i_b_valid,
    input logic                                 i_b_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    reset_quiet: assert property (@(posedge i_clk) !i_nrst |-> !i_r_valid && !i_b_valid)
        else $error("r_valid or b_valid high during reset");

    b_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_b_valid && !i_b_ready |=> i_b_valid)
        else $error("b_valid dropped before b_ready");

    last_with_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_r_last |-> i_r_valid)
        else $error("r_last without r_valid");

    // stalled beat must not change
    r_data_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_r_valid && !i_r_ready |=> i_r_valid && $stable(i_r_data))
        else $error("r_data changed under back-pressure");

endmodule

bind axi_slv axi_sram_asserts u_asserts (
    .i_clk     (i_clk),
    .i_nrst    (i_nrst),
    .i_r_valid (o_r_valid),
    .i_r_ready (i_r_ready),
    .i_r_data  (o_r_data),
    .i_r_last  (o_r_last),
    .i_b_valid (o_b_valid),
    .i_b_ready (i_b_ready)
);

// ==== verification/tb_axi_sram.sv ====
module tb_axi_sram;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 1000;
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_B  = 2;
    localparam int CH_AR = 3;

    logic                                 i_clk = 1'b0;
    logic                                 i_nrst;
    logic                                 i_aw_valid;
    logic                                 o_aw_ready;
    logic [axi_slv_pkg::ADDR_BITS-1:0]    i_aw_addr;
    logic [axi_slv_pkg::ID_BITS-1:0]      i_aw_id;
    logic [7:0]                           i_aw_len;
    logic [2:0]                           i_aw_size;
    logic [1:0]                           i_aw_burst;
    logic                                 i_w_valid;
    logic                                 o_w_ready;
    logic [axi_slv_pkg::DATA_BITS-1:0]    i_w_data;
    logic [axi_slv_pkg::DATA_BYTES-1:0]   i_w_strb;
    logic                                 o_b_valid;
    logic                                 i_b_ready;
    logic [axi_slv_pkg::ID_BITS-1:0]      o_b_id;
    logic [1:0]                           o_b_resp;
    logic                                 i_ar_valid;
    logic                                 o_ar_ready;
    logic [axi_slv_pkg::ADDR_BITS-1:0]    i_ar_addr;
    logic [axi_slv_pkg::ID_BITS-1:0]      i_ar_id;
    logic [7:0]                           i_ar_len;
    logic [2:0]                           i_ar_size;
    logic [1:0]                           i_ar_burst;
    logic                                 o_r_valid;
    logic                                 i_r_ready;
    logic [axi_slv_pkg::DATA_BITS-1:0]    o_r_data;
    logic [axi_slv_pkg::ID_BITS-1:0]      o_r_id;
    logic [1:0]                           o_r_resp;
    logic                                 o_r_last;

    logic [63:0] shadow [axi_slv_pkg::BANK_WORDS];  // reference memory
    integer      seed = 32'h9ff0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cyc = 0;
    int          rel_cyc;
    int          first_w_cyc;

    axi_sram_top u_dut (.*);

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // beat address per AXI burst rules
    function automatic logic [31:0] beat_addr(input logic [31:0] start, input int beat,
                                              input logic [2:0] size, input logic [1:0] burst);
        logic [31:0] offs;
        offs = 32'(beat) << size;
        case (burst)
            axi_slv_pkg::BURST_FIXED: return start;
            axi_slv_pkg::BURST_WRAP:  return {start[31:5], start[4:0] + offs[4:0]};
            default:                  return {start[31:12], start[11:0] + offs[11:0]};
        endcase
    endfunction

    function automatic logic [63:0] expect_beat(input logic [31:0] a, input logic [2:0] size);
        logic [63:0] w;
        w = shadow[a[10:3]];
        if (size == 3'd2 && a[2]) begin
            w = {2{w[63:32]}};  // upper word in both halves
        end
        return w;
    endfunction

    function automatic logic ready_of(input int ch);
        case (ch)
            CH_AW:   return o_aw_ready;
            CH_W:    return o_w_ready;
            CH_B:    return o_b_valid;
            default: return o_ar_ready;
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Errors found");
        $finish;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("%s: failed, %0d mismatches", name, errors - errs_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    // starts on a falling edge and returns 1 ns later with the handshake pending
    task automatic wait_for(input int ch, input string what);
        int n;
        n = 0;
        #1;
        while (!ready_of(ch) && n < TIMEOUT) begin
            @(negedge i_clk);
            #1;
            n++;
        end
        if (!ready_of(ch)) abort_run(what);
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [3:0] id, input int beats,
                               input logic [1:0] burst, input logic [7:0] strb);
        logic [31:0] a;
        logic [63:0] d;
        i_aw_valid = 1'b1;
        i_aw_addr  = addr;
        i_aw_id    = id;
        i_aw_len   = 8'(beats - 1);
        i_aw_size  = 3'd3;
        i_aw_burst = burst;
        wait_for(CH_AW, "AW never accepted");
        @(negedge i_clk);
        i_aw_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            a = beat_addr(addr, i, 3'd3, burst);
            d = {$random(seed), $random(seed)};
            i_w_valid = 1'b1;
            i_w_data  = d;
            i_w_strb  = strb;
            wait_for(CH_W, "W beat never accepted");
            if (i == 0) first_w_cyc = cyc;
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) shadow[a[10:3]][8*b +: 8] = d[8*b +: 8];
            end
            @(negedge i_clk);
        end
        i_w_valid = 1'b0;
        wait_for(CH_B, "no B response");
        @(negedge i_clk);  // one cycle of B back-pressure
        i_b_ready = 1'b1;
        #1;
        if (!o_b_valid) begin
            $display("Error at %0t ns: b_valid dropped before b_ready", $time);
            errors++;
        end
        if (o_b_id !== id) report_mismatch("o_b_id", 64'(o_b_id), 64'(id));
        if (o_b_resp !== 2'b00) report_mismatch("o_b_resp", 64'(o_b_resp), 64'd0);
        @(negedge i_clk);
        i_b_ready = 1'b0;
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [3:0] id, input int beats,
                              input logic [2:0] size, input logic [1:0] burst, input bit stall);
        logic [31:0] a;
        logic        last_exp;
        int          n;
        i_ar_valid = 1'b1;
        i_ar_addr  = addr;
        i_ar_id    = id;
        i_ar_len   = 8'(beats - 1);
        i_ar_size  = size;
        i_ar_burst = burst;
        wait_for(CH_AR, "AR never accepted");
        @(negedge i_clk);
        i_ar_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            a        = beat_addr(addr, i, size, burst);
            last_exp = (i == beats - 1);
            n        = 0;
            i_r_ready = stall ? rand_bit() : 1'b1;
            #1;
            while (!(o_r_valid && i_r_ready) && n < TIMEOUT) begin
                @(negedge i_clk);
                i_r_ready = stall ? rand_bit() : 1'b1;  // random back-pressure
                #1;
                n++;
            end
            if (!(o_r_valid && i_r_ready)) abort_run("R beat never arrived");
            if (o_r_data !== expect_beat(a, size)) begin
                report_mismatch("o_r_data", o_r_data, expect_beat(a, size));
            end
            if (o_r_id !== id) report_mismatch("o_r_id", 64'(o_r_id), 64'(id));
            if (o_r_last !== last_exp) report_mismatch("o_r_last", 64'(o_r_last), 64'(last_exp));
            if (o_r_resp !== 2'b00) report_mismatch("o_r_resp", 64'(o_r_resp), 64'd0);
            @(negedge i_clk);
        end
        i_r_ready = 1'b0;
        #1;
        if (o_r_valid) begin
            $display("Error at %0t ns: r_valid still high after the last beat", $time);
            errors++;
        end
        @(negedge i_clk);
    endtask

    task automatic test_init();
        int e;
        e = errors;
        #1;
        if (o_ar_ready !== 1'b1) report_mismatch("o_ar_ready", 64'(o_ar_ready), 64'd1);
        if (o_aw_ready !== 1'b1) report_mismatch("o_aw_ready", 64'(o_aw_ready), 64'd1);
        if (o_r_valid !== 1'b0) report_mismatch("o_r_valid", 64'(o_r_valid), 64'd0);
        if (o_b_valid !== 1'b0) report_mismatch("o_b_valid", 64'(o_b_valid), 64'd0);
        if (o_w_ready !== 1'b0) report_mismatch("o_w_ready", 64'(o_w_ready), 64'd0);
        @(negedge i_clk);
        // empty strobe so only the timing matters
        write_burst(32'h0000_0040, 4'h3, 1, axi_slv_pkg::BURST_INCR, 8'h00);
        if (first_w_cyc - rel_cyc < axi_slv_pkg::BANK_WORDS) begin
            $display("Error at %0t ns: w_ready came %0d cycles after reset, before the sweep end",
                     $time, first_w_cyc - rel_cyc);
            errors++;
        end
        read_burst(32'h0000_0000, 4'h1, 8, 3'd3, axi_slv_pkg::BURST_INCR, 1'b0);
        read_burst(32'h0000_07c0, 4'h2, 8, 3'd3, axi_slv_pkg::BURST_INCR, 1'b0);
        finish_test("init sweep", e);
    endtask

    task automatic test_strobe();
        int e;
        e = errors;
        write_burst(32'h0000_00a8, 4'h4, 1, axi_slv_pkg::BURST_INCR, 8'hff);
        write_burst(32'h0000_00a8, 4'hc, 1, axi_slv_pkg::BURST_INCR, 8'h5a);
        read_burst(32'h0000_00a0, 4'h1, 3, 3'd3, axi_slv_pkg::BURST_INCR, 1'b0);
        finish_test("partial strobe", e);
    endtask

    task automatic test_incr();
        int e;
        e = errors;
        write_burst(32'h0000_0180, 4'h5, 4, axi_slv_pkg::BURST_INCR, 8'hff);
        read_burst(32'h0000_0180, 4'h9, 4, 3'd3, axi_slv_pkg::BURST_INCR, 1'b0);
        finish_test("incr burst", e);
    endtask

    task automatic test_wrap();
        int e;
        e = errors;
        write_burst(32'h0000_0110, 4'h6, 4, axi_slv_pkg::BURST_WRAP, 8'hff);
        read_burst(32'h0000_0100, 4'h7, 4, 3'd3, axi_slv_pkg::BURST_INCR, 1'b0);  // block order
        read_burst(32'h0000_0110, 4'h8, 4, 3'd3, axi_slv_pkg::BURST_WRAP, 1'b0);
        finish_test("wrap burst", e);
    endtask

    task automatic test_narrow();
        int e;
        e = errors;
        write_burst(32'h0000_0208, 4'h2, 1, axi_slv_pkg::BURST_INCR, 8'hff);
        read_burst(32'h0000_020c, 4'h3, 1, 3'd2, axi_slv_pkg::BURST_INCR, 1'b0);
        read_burst(32'h0000_0208, 4'h4, 2, 3'd2, axi_slv_pkg::BURST_INCR, 1'b0);
        finish_test("32-bit read", e);
    endtask

    task automatic test_stall();
        int e;
        e = errors;
        write_burst(32'h0000_0300, 4'ha, 8, axi_slv_pkg::BURST_INCR, 8'hff);
        read_burst(32'h0000_0300, 4'hb, 8, 3'd3, axi_slv_pkg::BURST_INCR, 1'b1);
        read_burst(32'h0000_0180, 4'hd, 4, 3'd3, axi_slv_pkg::BURST_INCR, 1'b1);
        finish_test("read back-pressure", e);
    endtask

    initial begin
        i_nrst     = 1'b0;
        i_aw_valid = 1'b0;
        i_aw_addr  = '0;
        i_aw_id    = '0;
        i_aw_len   = '0;
        i_aw_size  = '0;
        i_aw_burst = '0;
        i_w_valid  = 1'b0;
        i_w_data   = '0;
        i_w_strb   = '0;
        i_b_ready  = 1'b0;
        i_ar_valid = 1'b0;
        i_ar_addr  = '0;
        i_ar_id    = '0;
        i_ar_len   = '0;
        i_ar_size  = '0;
        i_ar_burst = '0;
        i_r_ready  = 1'b0;
        for (int i = 0; i < axi_slv_pkg::BANK_WORDS; i++) begin
            shadow[i] = '0;  // bank sweeps to zero
        end
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst  = 1'b1;
        rel_cyc = cyc;
        test_init();
        test_strobe();
        test_incr();
        test_wrap();
        test_narrow();
        test_stall();
        $display("tests run %0d, tests failed %0d, error count %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/axi_slv_pkg.sv
src/axi_slv.sv
src/sram_bank.sv
src/axi_sram_top.sv
verification/axi_sram_asserts.sv
verification/tb_axi_sram.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_axi_sram
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
